// ==== include/rv_opcodes.svh ====
// RV32I opcode and funct3 constants for the integer ALU subset

// Major opcodes in instr[6:0]
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_OP     = 7'b0110011;

// funct3 in instr[14:12]
localparam logic [2:0] F3_ADD  = 3'b000;  // Also SUB in OP with bit 30
localparam logic [2:0] F3_SLL  = 3'b001;
localparam logic [2:0] F3_SLT  = 3'b010;
localparam logic [2:0] F3_SLTU = 3'b011;
localparam logic [2:0] F3_XOR  = 3'b100;
localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA with bit 30
localparam logic [2:0] F3_OR   = 3'b110;
localparam logic [2:0] F3_AND  = 3'b111;

// ==== hw/rv_core_pkg.sv ====
// Core types package: word, register index, ALU operation and pipeline payload structs
package rv_core_pkg;

	// Register and operand value
	typedef logic [31:0] word_t;

	// Register file index, x0 to x31
	typedef logic [4:0] reg_addr_t;

	// Shift amount, low five bits of operand b
	typedef logic [4:0] shamt_t;

	// Execute operations
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} alu_op_e;

	// Decode to execute payload, 73 bits
	typedef struct packed {
		word_t     op_a;   // rs1 or upper immediate
		word_t     op_b;   // rs2, immediate or shift amount
		reg_addr_t rd;     // Destination
		alu_op_e   op;
	} decoded_op_t;

	// Write-back payload, 37 bits
	typedef struct packed {
		reg_addr_t rd;
		word_t     data;
	} wb_t;

endpackage

// ==== hw/instr_queue.sv ====
// Instruction queue: circular FIFO of fetched words, head shown combinationally to decode
module instr_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic               i_push,       // Write strobe from environment
	input  rv_core_pkg::word_t i_instr,
	input  logic               i_pop,        // Head accepted by decode
	output logic               o_not_empty,
	output rv_core_pkg::word_t o_head,
	output logic               o_full
);
	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	rv_core_pkg::word_t mem [QUEUE_DEPTH];  // Entry storage
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W-1:0]   wr_ptr;
	logic [CNT_W-1:0]   count;              // Entries held

	// Wrap at depth, works for non power of two depths
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_push) wr_ptr <= ptr_inc(wr_ptr);
			if (i_pop)  rd_ptr <= ptr_inc(rd_ptr);
			case ({i_push, i_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_push) mem[wr_ptr] <= i_instr;
	end

	assign o_head      = mem[rd_ptr];
	assign o_not_empty = (count != '0);
	assign o_full      = (count == CNT_W'(QUEUE_DEPTH));

	// Environment must watch o_full
	a_no_push_full: assert property (@(posedge i_clock) disable iff (i_reset)
		i_push |-> !o_full);

	// Decode only pops a valid head
	a_no_pop_empty: assert property (@(posedge i_clock) disable iff (i_reset)
		i_pop |-> o_not_empty);

endmodule

// ==== hw/rv_decode.sv ====
// Instruction decode: classifies ALU instructions, reads sources and holds operands for execute
module rv_decode (
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_fetch_valid,  // Queue not empty
	input  rv_core_pkg::word_t       i_instr,        // Queue head
	output logic                     o_pop,
	output rv_core_pkg::reg_addr_t   o_ra_raddr,
	input  rv_core_pkg::word_t       i_ra_rdata,
	output rv_core_pkg::reg_addr_t   o_rb_raddr,
	input  rv_core_pkg::word_t       i_rb_rdata,
	output logic                     o_decode_valid,
	input  logic                     i_exec_ready,   // Completion pulse from execute
	output rv_core_pkg::decoded_op_t o_dec
);
	`include "rv_opcodes.svh"

	typedef enum logic [1:0] {
		ITYPE_LUI,
		ITYPE_OP_IMM,
		ITYPE_OP,
		ITYPE_OTHER   // Runs as ADD of zero
	} instr_type_e;

	typedef enum logic {
		IDLE,
		HOLD
	} dec_state_e;

	instr_type_e              instr_type;
	dec_state_e               state;
	logic [2:0]               funct3;
	logic                     alt;       // instr[30], SUB and SRA select
	logic                     is_shamt;  // Shift with immediate amount
	rv_core_pkg::word_t       imm_i;
	rv_core_pkg::word_t       imm_u;
	rv_core_pkg::decoded_op_t dec_next;

	assign funct3   = i_instr[14:12];
	assign alt      = i_instr[30];
	assign imm_i    = {{20{i_instr[31]}}, i_instr[31:20]};  // Sign extended
	assign imm_u    = {i_instr[31:12], 12'h000};
	assign is_shamt = (funct3 == F3_SLL) || (funct3 == F3_SR);

	// Source fields sit at fixed positions
	assign o_ra_raddr = i_instr[19:15];
	assign o_rb_raddr = i_instr[24:20];

	always_comb begin
		case (i_instr[6:0])
			OPC_LUI:    instr_type = ITYPE_LUI;
			OPC_OP_IMM: instr_type = ITYPE_OP_IMM;
			OPC_OP:     instr_type = ITYPE_OP;
			default:    instr_type = ITYPE_OTHER;
		endcase
	end

	// Operand select and operation mapping
	always_comb begin
		dec_next.rd = i_instr[11:7];  // Kept for every type
		case (instr_type)
			ITYPE_LUI: begin
				dec_next.op_a = imm_u;
				dec_next.op_b = '0;
			end
			ITYPE_OP_IMM: begin
				dec_next.op_a = i_ra_rdata;
				dec_next.op_b = is_shamt ? {27'b0, i_instr[24:20]} : imm_i;
			end
			ITYPE_OP: begin
				dec_next.op_a = i_ra_rdata;
				dec_next.op_b = i_rb_rdata;
			end
			default: begin
				dec_next.op_a = '0;
				dec_next.op_b = '0;
			end
		endcase

		dec_next.op = rv_core_pkg::ALU_ADD;  // LUI and unknown opcodes
		if (instr_type == ITYPE_OP_IMM || instr_type == ITYPE_OP) begin
			case (funct3)
				F3_ADD:  dec_next.op = (instr_type == ITYPE_OP && alt) ?
					rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;  // ADDI has no SUB form
				F3_SLL:  dec_next.op = rv_core_pkg::ALU_SLL;
				F3_SLT:  dec_next.op = rv_core_pkg::ALU_SLT;
				F3_SLTU: dec_next.op = rv_core_pkg::ALU_SLTU;
				F3_XOR:  dec_next.op = rv_core_pkg::ALU_XOR;
				F3_SR:   dec_next.op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
				F3_OR:   dec_next.op = rv_core_pkg::ALU_OR;
				F3_AND:  dec_next.op = rv_core_pkg::ALU_AND;
				default: dec_next.op = rv_core_pkg::ALU_ADD;
			endcase
		end
	end

	// Take head only when nothing is held
	assign o_pop = (state == IDLE) && i_fetch_valid;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state          <= IDLE;
			o_decode_valid <= 1'b0;
		end else begin
			case (state)
				IDLE: if (i_fetch_valid) begin
					state          <= HOLD;
					o_decode_valid <= 1'b1;
				end
				HOLD: if (i_exec_ready) begin  // Write-back lands this edge
					state          <= IDLE;
					o_decode_valid <= 1'b0;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Operand hold register
	always_ff @(posedge i_clock) begin
		if (o_pop) o_dec <= dec_next;
	end

	// Execute reads o_dec across a multi-cycle shift
	a_hold_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		o_decode_valid && !i_exec_ready |=> $stable(o_dec));

endmodule

// ==== hw/reg_file.sv ====
// Register file: 32 words, two combinational read ports, one write port, x0 held at zero
module reg_file (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  rv_core_pkg::reg_addr_t i_ra_raddr,
	output rv_core_pkg::word_t     o_ra_rdata,
	input  rv_core_pkg::reg_addr_t i_rb_raddr,
	output rv_core_pkg::word_t     o_rb_rdata,
	input  logic                   i_wb_valid,
	input  rv_core_pkg::wb_t       i_wb
);
	rv_core_pkg::word_t regs [32];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb_valid && (i_wb.rd != '0)) begin  // x0 writes dropped
			regs[i_wb.rd] <= i_wb.data;
		end
	end

	// Same-cycle read, new value visible after the write edge
	assign o_ra_rdata = regs[i_ra_raddr];
	assign o_rb_rdata = regs[i_rb_raddr];

endmodule

// ==== hw/alu_exec.sv ====
// Execute unit: single-cycle ALU plus bit-serial shifter, drives register write-back
module alu_exec (
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_decode_valid,
	input  rv_core_pkg::decoded_op_t i_dec,
	output logic                     o_exec_ready,  // Completion pulse
	output logic                     o_wb_valid,
	output rv_core_pkg::wb_t         o_wb
);
	typedef enum logic {
		EX_IDLE,
		EX_SHIFT
	} exec_state_e;

	exec_state_e         state;
	rv_core_pkg::word_t  sh_data;      // Partial shift result
	rv_core_pkg::shamt_t sh_cnt;       // Steps still to go
	rv_core_pkg::shamt_t shamt;
	rv_core_pkg::word_t  sh_step_in;
	rv_core_pkg::word_t  sh_step;      // One position moved
	rv_core_pkg::word_t  alu_res;
	logic                is_shift;
	logic                start_shift;

	assign shamt    = i_dec.op_b[4:0];
	assign is_shift = (i_dec.op == rv_core_pkg::ALU_SLL) ||
		(i_dec.op == rv_core_pkg::ALU_SRL) || (i_dec.op == rv_core_pkg::ALU_SRA);

	// First step works on op_a, later ones on the held value
	assign sh_step_in = (state == EX_IDLE) ? i_dec.op_a : sh_data;

	always_comb begin
		case (i_dec.op)
			rv_core_pkg::ALU_SLL: sh_step = {sh_step_in[30:0], 1'b0};
			rv_core_pkg::ALU_SRA: sh_step = {sh_step_in[31], sh_step_in[31:1]};  // Sign fill
			default:              sh_step = {1'b0, sh_step_in[31:1]};
		endcase
	end

	always_comb begin
		case (i_dec.op)
			rv_core_pkg::ALU_ADD:  alu_res = i_dec.op_a + i_dec.op_b;
			rv_core_pkg::ALU_SUB:  alu_res = i_dec.op_a - i_dec.op_b;
			rv_core_pkg::ALU_SLT:  alu_res = {31'b0, $signed(i_dec.op_a) < $signed(i_dec.op_b)};
			rv_core_pkg::ALU_SLTU: alu_res = {31'b0, i_dec.op_a < i_dec.op_b};
			rv_core_pkg::ALU_XOR:  alu_res = i_dec.op_a ^ i_dec.op_b;
			rv_core_pkg::ALU_OR:   alu_res = i_dec.op_a | i_dec.op_b;
			rv_core_pkg::ALU_AND:  alu_res = i_dec.op_a & i_dec.op_b;
			default:               alu_res = i_dec.op_a;  // Shift by zero
		endcase
	end

	// Nonzero shifts leave the single-cycle path
	assign start_shift = (state == EX_IDLE) && i_decode_valid && is_shift && (shamt != '0);

	always_comb begin
		o_wb.rd = i_dec.rd;  // Decode holds rd through the shift
		if (state == EX_SHIFT) begin
			o_wb_valid = (sh_cnt == '0);
			o_wb.data  = sh_data;
		end else begin
			o_wb_valid = i_decode_valid && !start_shift;
			o_wb.data  = alu_res;
		end
	end

	assign o_exec_ready = o_wb_valid;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state  <= EX_IDLE;
			sh_cnt <= '0;
		end else begin
			case (state)
				EX_IDLE: if (start_shift) begin
					state  <= EX_SHIFT;
					sh_cnt <= shamt - 5'd1;  // First step taken at load
				end
				EX_SHIFT: begin
					if (sh_cnt == '0) state <= EX_IDLE;
					else              sh_cnt <= sh_cnt - 5'd1;
				end
				default: state <= EX_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (start_shift || (state == EX_SHIFT && sh_cnt != '0)) sh_data <= sh_step;
	end

	// Decode must keep the operation presented until write-back
	a_wb_in_transfer: assert property (@(posedge i_clock) disable iff (i_reset)
		o_wb_valid |-> i_decode_valid);

endmodule

// ==== hw/rv_core_top.sv ====
// Integer execute path top: instruction queue, decode, register file and serial ALU
module rv_core_top #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic               i_push,
	input  rv_core_pkg::word_t i_instr,
	output logic               o_full,
	output logic               o_wb_valid,
	output rv_core_pkg::wb_t   o_wb        // Write-back trace
);
	rv_core_pkg::word_t       head_instr;
	logic                     queue_not_empty;
	logic                     pop;
	rv_core_pkg::reg_addr_t   ra_raddr;
	rv_core_pkg::reg_addr_t   rb_raddr;
	rv_core_pkg::word_t       ra_rdata;
	rv_core_pkg::word_t       rb_rdata;
	logic                     decode_valid;
	logic                     exec_ready;
	rv_core_pkg::decoded_op_t dec;

	instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_push(i_push), .i_instr(i_instr),
		.i_pop(pop), .o_not_empty(queue_not_empty),
		.o_head(head_instr), .o_full(o_full)
	);

	rv_decode i_decode (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_fetch_valid(queue_not_empty), .i_instr(head_instr), .o_pop(pop),
		.o_ra_raddr(ra_raddr), .i_ra_rdata(ra_rdata),
		.o_rb_raddr(rb_raddr), .i_rb_rdata(rb_rdata),
		.o_decode_valid(decode_valid), .i_exec_ready(exec_ready), .o_dec(dec)
	);

	reg_file i_regs (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_ra_raddr(ra_raddr), .o_ra_rdata(ra_rdata),
		.i_rb_raddr(rb_raddr), .o_rb_rdata(rb_rdata),
		.i_wb_valid(o_wb_valid), .i_wb(o_wb)
	);

	alu_exec i_exec (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_decode_valid(decode_valid), .i_dec(dec),
		.o_exec_ready(exec_ready), .o_wb_valid(o_wb_valid), .o_wb(o_wb)
	);

endmodule

// ==== tests/tb_rv_core.sv ====
// Integer execute path testbench with random and directed ALU programs checked against a model
module tb_rv_core;
	timeunit 1ns;
	timeprecision 100ps;

	`include "rv_opcodes.svh"

	localparam int QUEUE_DEPTH  = 4;
	localparam int RESET_CYCLES = 16;
	localparam int CLK_PERIOD   = 4;
	localparam int N_PUSH       = 9 + 300 + 51 + 5 + 13;  // Pushes of tests 2 to 6
	localparam int WATCHDOG_NS  = (RESET_CYCLES + 40 * N_PUSH) * CLK_PERIOD;

	logic                     clock = 1'b0;
	logic                     reset = 1'b1;
	logic                     push  = 1'b0;
	rv_core_pkg::word_t       instr = '0;
	logic                     full;
	logic                     wb_valid;
	rv_core_pkg::wb_t         wb;

	rv_core_pkg::word_t       model_regs [32];  // Architectural state of the model
	rv_core_pkg::wb_t         exp_q [$];        // Expected write-backs in push order
	rv_core_pkg::wb_t         exp_wb;
	rv_core_pkg::word_t       rng = 32'd49618;
	int                       pass_count = 0;
	int                       fail_count = 0;
	int                       wb_count = 0;
	logic                     saw_full = 1'b0;

	always #(CLK_PERIOD / 2) clock = ~clock;

	rv_core_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_dut (
		.i_clock(clock), .i_reset(reset),
		.i_push(push), .i_instr(instr), .o_full(full),
		.o_wb_valid(wb_valid), .o_wb(wb)
	);

	// 32-bit xorshift
	function automatic rv_core_pkg::word_t rand_word();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic rv_core_pkg::word_t enc_i(input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	function automatic rv_core_pkg::word_t enc_r(input logic alt, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic rv_core_pkg::word_t enc_u(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, OPC_LUI};
	endfunction

	// RV32I integer result for one funct3 with alt picking SUB or SRA
	function automatic rv_core_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
			input rv_core_pkg::word_t a, input rv_core_pkg::word_t b);
		case (f3)
			F3_ADD:  return alt ? a - b : a + b;
			F3_SLL:  return a << b[4:0];
			F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
			F3_XOR:  return a ^ b;
			F3_SR:   return alt ? rv_core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			F3_OR:   return a | b;
			default: return a & b;
		endcase
	endfunction

	// Expected write-back of one instruction against the model registers
	function automatic rv_core_pkg::wb_t ref_exec(input rv_core_pkg::word_t ins);
		rv_core_pkg::wb_t   r;
		rv_core_pkg::word_t a;
		rv_core_pkg::word_t imm;
		logic [2:0]         f3;
		a      = model_regs[ins[19:15]];
		f3     = ins[14:12];
		imm    = {{20{ins[31]}}, ins[31:20]};
		r.rd   = ins[11:7];
		r.data = '0;  // Unknown opcodes give zero
		case (ins[6:0])
			OPC_LUI:    r.data = {ins[31:12], 12'h000};
			OPC_OP_IMM: r.data = alu_ref(f3, ins[30] && (f3 == F3_SR), a, imm);  // No SUBI
			OPC_OP:     r.data = alu_ref(f3, ins[30], a, model_regs[ins[24:20]]);
			default:    r.data = '0;
		endcase
		return r;
	endfunction

	task automatic check_value(input string what, input rv_core_pkg::word_t expected,
			input rv_core_pkg::word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH at time %0t: %s expected %h got %h", $time, what, expected, actual);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	// Push when there is room and run the model in push order
	task automatic push_instr(input rv_core_pkg::word_t ins);
		rv_core_pkg::wb_t e;
		while (full) begin
			@(posedge clock);
			#0.5;
		end
		e = ref_exec(ins);
		if (e.rd != 5'd0) model_regs[e.rd] = e.data;
		exp_q.push_back(e);
		push  = 1'b1;
		instr = ins;
		@(posedge clock);
		#0.5;
		push  = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clock);
			#0.5;
		end
	endtask

	task automatic end_test(input string name, input int fails_before);
		wait_drain();
		$display("Test %s %s", name, (fail_count == fails_before) ? "passed" : "FAILED");
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clock) begin
		if (!reset && wb_valid) begin
			wb_count++;  // Every pulse on the port
			if (exp_q.size() == 0) begin
				$display("Unexpected write-back at time %0t: rd %0d data %h, nothing outstanding",
					$time, wb.rd, wb.data);
				fail_count++;
			end else begin
				exp_wb = exp_q.pop_front();
				check_value("write-back rd", 32'(exp_wb.rd), 32'(wb.rd));
				check_value("write-back data", exp_wb.data, wb.data);
			end
		end
		if (full) saw_full = 1'b1;  // Queue reached depth
	end

	initial begin
		int                 fails_before;
		int                 wb_before;
		rv_core_pkg::word_t r;
		logic [2:0]         f3;
		logic               alt;
		logic [4:0]         amt;
		for (int i = 0; i < 32; i++) model_regs[i] = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		#0.5;
		reset = 1'b0;

		fails_before = fail_count;  // Idle after reset
		repeat (10) begin
			check_value("o_wb_valid after reset", 32'd0, 32'(wb_valid));
			check_value("o_full after reset", 32'd0, 32'(full));
			@(posedge clock);
			#0.5;
		end
		end_test("reset_idle", fails_before);

		fails_before = fail_count;
		push_instr(enc_u(5'd1, 20'h12345));
		push_instr(enc_i(F3_ADD, 5'd1, 5'd1, 12'h678));
		push_instr(enc_i(F3_ADD, 5'd2, 5'd0, 12'hfff));   // -1
		push_instr(enc_u(5'd3, 20'hfffff));
		push_instr(enc_i(F3_ADD, 5'd3, 5'd3, 12'h800));   // -2048
		push_instr(enc_i(F3_ADD, 5'd4, 5'd0, 12'd5));
		push_instr(enc_i(F3_SLTU, 5'd5, 5'd4, 12'hfff));  // Compares with all ones
		push_instr(enc_i(F3_SLTU, 5'd6, 5'd2, 12'hfff));
		push_instr(enc_i(F3_SLT, 5'd7, 5'd2, 12'd1));
		end_test("lui_addi_constants", fails_before);

		fails_before = fail_count;
		for (int n = 0; n < 300; n++) begin
			r   = rand_word();
			f3  = r[3:1];
			alt = r[19] && ((f3 == F3_SR) || (r[0] && f3 == F3_ADD));  // Legal encodings only
			if (r[0])
				push_instr(enc_r(alt, f3, r[8:4], r[13:9], r[18:14]));
			else if (f3 == F3_SLL || f3 == F3_SR)
				push_instr(enc_i(f3, r[8:4], r[13:9], {1'b0, alt, 5'b0, r[24:20]}));
			else
				push_instr(enc_i(f3, r[8:4], r[13:9], r[31:20]));
		end
		end_test("random_alu", fails_before);

		fails_before = fail_count;
		push_instr(enc_u(5'd8, 20'h80f0f));  // Negative source for SRA fill
		push_instr(enc_i(F3_ADD, 5'd8, 5'd8, 12'h123));
		for (int k = 0; k < 7; k++) begin
			r = rand_word();
			case (k)
				0:       amt = 5'd0;
				1:       amt = 5'd1;
				2:       amt = 5'd31;
				default: amt = r[4:0];
			endcase
			push_instr(enc_i(F3_ADD, 5'd9, 5'd0, {1'b0, r[10:5], amt}));  // Upper bits ignored
			push_instr(enc_r(1'b0, F3_SLL, 5'd10, 5'd8, 5'd9));
			push_instr(enc_r(1'b0, F3_SR, 5'd11, 5'd8, 5'd9));
			push_instr(enc_r(1'b1, F3_SR, 5'd12, 5'd8, 5'd9));
			push_instr(enc_i(F3_SLL, 5'd13, 5'd8, {7'b0, amt}));
			push_instr(enc_i(F3_SR, 5'd14, 5'd8, {7'b0, amt}));
			push_instr(enc_i(F3_SR, 5'd15, 5'd8, {7'b0100000, amt}));
		end
		end_test("shifts", fails_before);

		fails_before = fail_count;
		push_instr(enc_i(F3_ADD, 5'd0, 5'd0, 12'd123));  // Shows on o_wb but is not kept
		push_instr(enc_r(1'b0, F3_ADD, 5'd10, 5'd0, 5'd0));
		push_instr(enc_u(5'd0, 20'habcde));
		push_instr(enc_i(F3_ADD, 5'd13, 5'd0, 12'd1));
		push_instr(enc_r(1'b0, F3_OR, 5'd16, 5'd8, 5'd0));
		end_test("x0_writes", fails_before);

		fails_before = fail_count;
		wb_before    = wb_count;
		push_instr(enc_u(5'd14, 20'hc0000));
		saw_full = 1'b0;
		for (int i = 0; i < 12; i++) begin
			amt = 5'(31 - i);  // Long shifts stall execute
			case (i % 3)
				0:       r = enc_i(F3_SR, 5'(16 + i), 5'd14, {7'b0100000, amt});
				1:       r = enc_i(F3_SR, 5'(16 + i), 5'd14, {7'b0, amt});
				default: r = enc_i(F3_SLL, 5'(16 + i), 5'd14, {7'b0, amt});
			endcase
			push_instr(r);
		end
		wait_drain();
		repeat (40) begin  // Longer than the slowest shift, catches a repeated write-back
			@(posedge clock);
			#0.5;
		end
		check_value("o_full seen during burst", 32'd1, 32'(saw_full));
		check_value("write-back count of burst", 32'd13, 32'(wb_count - wb_before));
		end_test("back_pressure", fails_before);

		$display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Bound from the number of pushes
	initial begin
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns with %0d write-backs still outstanding",
			WATCHDOG_NS, exp_q.size());
		$display("Something failed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+include
hw/rv_core_pkg.sv
hw/instr_queue.sv
hw/rv_decode.sv
hw/reg_file.sv
hw/alu_exec.sv
hw/rv_core_top.sv
tests/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_rv_core -f sim.f --Mdir obj_dir -o tb_rv_core

./obj_dir/tb_rv_core 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

echo "Simulation finished without failures"
